// File: Makefile
# Verilator simulation of the five-stage core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for a failure"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module cpu_tb -f src.f -o Vcpu_tb
	./obj_dir/Vcpu_tb 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "Simulation ended without passing"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: hw/cpu.sv
`timescale 1ns/1ps

module cpu import pipe_pkg::*; #(
    parameter int WIDTH       = 32,
    parameter int DMEM_AWIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [31:0]            instr_i,
    output logic [WIDTH-1:0]       pc_o,
    input  logic [WIDTH-1:0]       dmem_rdata_i,
    output logic                   dmem_w_en_o,
    output logic [WIDTH-1:0]       dmem_wdata_o,
    output logic [DMEM_AWIDTH-1:0] dmem_addr_o
);

    if_id_t           if_id;
    id_ex_t           id_ex;
    ex_mem_t          ex_mem;
    rf_wr_t           rf_wr;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [WIDTH-1:0] rs1_data;
    logic [WIDTH-1:0] rs2_data;
    logic             br_taken;
    logic [WIDTH-1:0] br_target;

    fetch #(.WIDTH(WIDTH)) fetch_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .br_taken_i  (br_taken),
        .br_target_i (br_target),
        .instr_i     (instr_i),
        .pc_o        (pc_o),
        .if_id_o     (if_id)
    );

    decode #(.WIDTH(WIDTH)) decode_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .if_id_i     (if_id),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .br_taken_o  (br_taken),
        .br_target_o (br_target),
        .id_ex_o     (id_ex)
    );

    regfile #(.WIDTH(WIDTH)) regfile_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_i       (rf_wr),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute #(.WIDTH(WIDTH)) execute_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .id_ex_i  (id_ex),
        .ex_mem_o (ex_mem)
    );

    memory_access #(
        .WIDTH       (WIDTH),
        .DMEM_AWIDTH (DMEM_AWIDTH)
    ) memory_access_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .ex_mem_i     (ex_mem),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_w_en_o  (dmem_w_en_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_addr_o  (dmem_addr_o),
        .rf_wr_o      (rf_wr)
    );

endmodule

// File: hw/decode.sv
`timescale 1ns/1ps

module decode import isa_pkg::*, pipe_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_i,
    input  if_id_t           if_id_i,
    output logic [4:0]       rs1_addr_o,
    output logic [4:0]       rs2_addr_o,
    input  logic [WIDTH-1:0] rs1_data_i,
    input  logic [WIDTH-1:0] rs2_data_i,
    output logic             br_taken_o,
    output logic [WIDTH-1:0] br_target_o,
    output id_ex_t           id_ex_o
);

    logic [31:0]      instr;
    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [WIDTH-1:0] imm_i;
    logic [WIDTH-1:0] imm_s;
    logic [WIDTH-1:0] imm_b;
    logic [WIDTH-1:0] imm_u;
    logic [WIDTH-1:0] imm_j;
    id_ex_t           id_ex_d;

    assign instr      = if_id_i.instr;
    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7     = instr[31:25];
    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    // Sign-extended immediates
    assign imm_i = {{(WIDTH-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(WIDTH-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(WIDTH-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = WIDTH'($signed({instr[31:12], 12'b0}));
    assign imm_j = {{(WIDTH-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // Branches and JAL resolve here
    always_comb begin
        br_taken_o  = 1'b0;
        br_target_o = if_id_i.pc + imm_b;
        case (opcode)
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    br_taken_o = (rs1_data_i == rs2_data_i);
                end else if (funct3 == F3_BNE) begin
                    br_taken_o = (rs1_data_i != rs2_data_i);
                end
            end
            OPC_JAL: begin
                br_taken_o  = 1'b1;
                br_target_o = if_id_i.pc + imm_j;
            end
            default: ;
        endcase
    end

    always_comb begin
        id_ex_d.pc       = if_id_i.pc;
        id_ex_d.rs1_data = rs1_data_i;
        id_ex_d.rs2_data = rs2_data_i;
        id_ex_d.imm      = imm_i;
        id_ex_d.rd_addr  = instr[11:7];
        id_ex_d.rf_w_en  = 1'b0;
        id_ex_d.mem_w_en = 1'b0;
        id_ex_d.alu_func = ALU_ADD;
        id_ex_d.opsel1   = SEL_REG;
        id_ex_d.opsel2   = SEL_REG;
        id_ex_d.wbsel    = WB_ALU;
        case (opcode)
            OPC_OP: begin
                id_ex_d.rf_w_en = 1'b1;
                case (funct3)
                    F3_ADD_SUB: id_ex_d.alu_func = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     id_ex_d.alu_func = ALU_SLT;
                    F3_XOR:     id_ex_d.alu_func = ALU_XOR;
                    F3_OR:      id_ex_d.alu_func = ALU_OR;
                    F3_AND:     id_ex_d.alu_func = ALU_AND;
                    default:    id_ex_d.rf_w_en  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                id_ex_d.rf_w_en = (funct3 == F3_ADD_SUB);
                id_ex_d.opsel2  = SEL_IMM;
            end
            OPC_LUI: begin
                id_ex_d.rf_w_en  = 1'b1;
                id_ex_d.imm      = imm_u;
                id_ex_d.opsel1   = SEL_ZERO;
                id_ex_d.opsel2   = SEL_IMM;
                id_ex_d.alu_func = ALU_PASS_B;
                id_ex_d.wbsel    = WB_IMM;
            end
            OPC_LOAD: begin
                id_ex_d.rf_w_en = (funct3 == F3_LW);
                id_ex_d.opsel2  = SEL_IMM;
                id_ex_d.wbsel   = WB_LOAD;
            end
            OPC_STORE: begin
                id_ex_d.mem_w_en = (funct3 == F3_SW);
                id_ex_d.imm      = imm_s;
                id_ex_d.opsel2   = SEL_IMM;
            end
            OPC_JAL: begin
                id_ex_d.rf_w_en = 1'b1;
                id_ex_d.imm     = imm_j;
                id_ex_d.opsel1  = SEL_PC;
                id_ex_d.opsel2  = SEL_IMM;
                id_ex_d.wbsel   = WB_PC4;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        id_ex_o <= id_ex_d;
        if (rst_i) begin
            id_ex_o.rf_w_en  <= 1'b0;
            id_ex_o.mem_w_en <= 1'b0;
        end
    end

endmodule

// File: hw/execute.sv
`timescale 1ns/1ps

module execute import isa_pkg::*, pipe_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic    clk,
    input  logic    rst_i,
    input  id_ex_t  id_ex_i,
    output ex_mem_t ex_mem_o
);

    logic [WIDTH-1:0] op_a;
    logic [WIDTH-1:0] op_b;
    logic [WIDTH-1:0] alu_result;

    function automatic logic [WIDTH-1:0] sel_operand(input opsel_e sel,
                                                     input logic [WIDTH-1:0] rs_data);
        unique case (sel)
            SEL_REG:  return rs_data;
            SEL_IMM:  return id_ex_i.imm;
            SEL_PC:   return id_ex_i.pc;
            SEL_ZERO: return '0;
        endcase
    endfunction

    always_comb begin
        op_a = sel_operand(id_ex_i.opsel1, id_ex_i.rs1_data);
        op_b = sel_operand(id_ex_i.opsel2, id_ex_i.rs2_data);
        case (id_ex_i.alu_func)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = WIDTH'($signed(op_a) < $signed(op_b));
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        ex_mem_o.pc         <= id_ex_i.pc;
        ex_mem_o.alu_result <= alu_result;
        ex_mem_o.rs2_data   <= id_ex_i.rs2_data;
        ex_mem_o.imm        <= id_ex_i.imm;
        ex_mem_o.rd_addr    <= id_ex_i.rd_addr;
        ex_mem_o.wbsel      <= id_ex_i.wbsel;
        ex_mem_o.rf_w_en    <= id_ex_i.rf_w_en;
        ex_mem_o.mem_w_en   <= id_ex_i.mem_w_en;
        if (rst_i) begin
            ex_mem_o.rf_w_en  <= 1'b0;
            ex_mem_o.mem_w_en <= 1'b0;
        end
    end

endmodule

// File: hw/fetch.sv
`timescale 1ns/1ps

module fetch import isa_pkg::*, pipe_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             br_taken_i,
    input  logic [WIDTH-1:0] br_target_i,
    input  logic [31:0]      instr_i,
    output logic [WIDTH-1:0] pc_o,
    output if_id_t           if_id_o
);

    logic [WIDTH-1:0] pc_q;

    assign pc_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= '0;
        end else if (br_taken_i) begin
            pc_q <= br_target_i;
        end else begin
            pc_q <= pc_q + WIDTH'(4);
        end
    end

    // Wrong-path fetch turns into a bubble
    always_ff @(posedge clk) begin
        if_id_o.pc <= pc_q;
        if (rst_i || br_taken_i) begin
            if_id_o.instr <= NOP_INSTR;
        end else begin
            if_id_o.instr <= instr_i;
        end
    end

endmodule

// File: hw/isa_pkg.sv
package isa_pkg;

    // RV32I major opcodes in use
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;

    // funct7 values
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_func_e;

    typedef enum logic [1:0] {
        SEL_REG,
        SEL_IMM,
        SEL_PC,
        SEL_ZERO
    } opsel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_IMM
    } wbsel_e;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// File: hw/memory_access.sv
`timescale 1ns/1ps

module memory_access import isa_pkg::*, pipe_pkg::*; #(
    parameter int WIDTH       = 32,
    parameter int DMEM_AWIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  ex_mem_t                ex_mem_i,
    input  logic [WIDTH-1:0]       dmem_rdata_i,
    output logic                   dmem_w_en_o,
    output logic [WIDTH-1:0]       dmem_wdata_o,
    output logic [DMEM_AWIDTH-1:0] dmem_addr_o,
    output rf_wr_t                 rf_wr_o
);

    logic [WIDTH-1:0] wb_data;

    // Word address from the byte address
    assign dmem_w_en_o  = ex_mem_i.mem_w_en;
    assign dmem_wdata_o = ex_mem_i.rs2_data;
    assign dmem_addr_o  = ex_mem_i.alu_result[DMEM_AWIDTH+1:2];

    always_comb begin
        unique case (ex_mem_i.wbsel)
            WB_ALU:  wb_data = ex_mem_i.alu_result;
            WB_LOAD: wb_data = dmem_rdata_i;
            WB_PC4:  wb_data = ex_mem_i.pc + WIDTH'(4);
            WB_IMM:  wb_data = ex_mem_i.imm;
        endcase
    end

    always_ff @(posedge clk) begin
        rf_wr_o.rd_addr <= ex_mem_i.rd_addr;
        rf_wr_o.data    <= wb_data;
        rf_wr_o.w_en    <= rst_i ? 1'b0 : ex_mem_i.rf_w_en;
    end

endmodule

// File: hw/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    localparam int XLEN = 32;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [4:0]      rd_addr;
        logic            rf_w_en;
        logic            mem_w_en;
        alu_func_e       alu_func;
        opsel_e          opsel1;
        opsel_e          opsel2;
        wbsel_e          wbsel;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [4:0]      rd_addr;
        logic            rf_w_en;
        logic            mem_w_en;
        wbsel_e          wbsel;
    } ex_mem_t;

    // Register file write port
    typedef struct packed {
        logic            w_en;
        logic [4:0]      rd_addr;
        logic [XLEN-1:0] data;
    } rf_wr_t;

endpackage

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile import pipe_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_i,
    input  rf_wr_t           wr_i,
    input  logic [4:0]       rs1_addr_i,
    input  logic [4:0]       rs2_addr_i,
    output logic [WIDTH-1:0] rs1_data_o,
    output logic [WIDTH-1:0] rs2_data_o
);

    logic [WIDTH-1:0] regs [32];

    // Write-through so decode sees the value retiring this cycle
    function automatic logic [WIDTH-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wr_i.w_en && wr_i.rd_addr == addr) begin
            return wr_i.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.w_en && wr_i.rd_addr != 5'd0) begin
            regs[wr_i.rd_addr] <= wr_i.data;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

// File: src.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch.sv
hw/decode.sv
hw/regfile.sv
hw/execute.sv
hw/memory_access.sv
hw/cpu.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

// File: verif/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva #(
    parameter int WIDTH       = 32,
    parameter int DMEM_AWIDTH = 6
) (
    input logic                   clk,
    input logic                   rst_i,
    input logic [WIDTH-1:0]       pc_i,
    input logic                   br_taken_i,
    input logic                   dmem_w_en_i,
    input logic [WIDTH-1:0]       dmem_wdata_i,
    input logic [DMEM_AWIDTH-1:0] dmem_addr_i
);

    no_store_in_reset: assert property (@(posedge clk) rst_i && $past(rst_i) |-> !dmem_w_en_i)
        else $error("data memory write enable high during reset");

    no_store_after_reset: assert property (@(posedge clk) $fell(rst_i) |-> !dmem_w_en_i)
        else $error("data memory write enable high right after reset");

    pc_aligned: assert property (@(posedge clk) disable iff (rst_i) pc_i[1:0] == 2'b00)
        else $error("program counter not word aligned");

    // Sequential fetch unless decode redirected the previous cycle
    pc_step: assert property (@(posedge clk) disable iff (rst_i)
        !$past(rst_i) && !$past(br_taken_i) |-> pc_i == $past(pc_i) + WIDTH'(4))
        else $error("program counter did not advance by 4");

    store_known: assert property (@(posedge clk)
        dmem_w_en_i |-> !$isunknown({dmem_addr_i, dmem_wdata_i}))
        else $error("unknown address or data on a store");

endmodule

bind cpu cpu_sva #(
    .WIDTH       (WIDTH),
    .DMEM_AWIDTH (DMEM_AWIDTH)
) cpu_sva_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .pc_i         (pc_o),
    .br_taken_i   (br_taken),
    .dmem_w_en_i  (dmem_w_en_o),
    .dmem_wdata_i (dmem_wdata_o),
    .dmem_addr_i  (dmem_addr_o)
);

// File: verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import isa_pkg::*; ();

    localparam logic [31:0] SEED       = 32'h5d06_1ed3;
    localparam int          IMEM_WORDS = 128;
    localparam logic [31:0] MARKER     = 32'h0000_05a5;

    typedef struct packed {
        logic [5:0]  addr;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        rst_i;
    logic [31:0] instr_i;
    logic [31:0] pc_o;
    logic [31:0] dmem_rdata_i;
    logic        dmem_w_en_o;
    logic [31:0] dmem_wdata_o;
    logic [5:0]  dmem_addr_o;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [64];
    store_t      exp_q [$];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] park_pc;
    int          prog_len;
    int          limit;
    int          cycles;
    int          parked;
    int          errors;
    int          timeouts;

    cpu #(
        .WIDTH       (32),
        .DMEM_AWIDTH (6)
    ) cpu_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .instr_i      (instr_i),
        .pc_o         (pc_o),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_w_en_o  (dmem_w_en_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_addr_o  (dmem_addr_o)
    );

    // Both memories answer combinationally
    assign instr_i      = imem[pc_o[8:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Data memory with an address-dependent fill
    initial begin
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hd00d_0000 | (32'(i) * 32'h0101);
        end
        forever begin
            @(posedge clk);
            if (dmem_w_en_o) begin
                dmem[dmem_addr_o] <= dmem_wdata_o;
            end
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic put_instr(input logic [31:0] instr);
        imem[prog_len[6:0]] = instr;
        prog_len++;
    endtask

    // Two slots keep a consumer clear of its producer
    task automatic pad_hazard();
        put_instr(NOP_INSTR);
        put_instr(NOP_INSTR);
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        put_instr({upper[31:12], rd, OPC_LUI});
        pad_hazard();
        put_instr(i_type(value[11:0], rd, F3_ADD_SUB, rd, OPC_OP_IMM));
    endtask

    task automatic put_store(input int word, input logic [4:0] rs2, input logic [31:0] data);
        store_t s;
        s.addr = 6'(word);
        s.data = data;
        put_instr(s_type(12'(word * 4), rs2, 5'd0));
        exp_q.push_back(s);
    endtask

    task automatic build_program();
        logic [31:0] jal_pc;
        load_const(5'd1, a);
        load_const(5'd2, b);
        pad_hazard();
        put_store(1, 5'd1, a);
        put_store(2, 5'd2, b);
        put_instr(r_type(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
        put_instr(r_type(F7_SUB, 5'd2, 5'd1, F3_ADD_SUB, 5'd4));
        put_instr(r_type(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd5));
        put_instr(r_type(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd6));
        put_instr(r_type(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd7));
        put_instr(r_type(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd8));
        pad_hazard();
        put_store(3, 5'd3, a + b);
        put_store(4, 5'd4, a - b);
        put_store(5, 5'd5, a & b);
        put_store(6, 5'd6, a | b);
        put_store(7, 5'd7, a ^ b);
        put_store(8, 5'd8, 32'($signed(a) < $signed(b)));
        // Reload word 1 and copy it out
        put_instr(i_type(12'd4, 5'd0, F3_LW, 5'd9, OPC_LOAD));
        pad_hazard();
        put_store(9, 5'd9, a);
        put_instr(i_type(MARKER[11:0], 5'd0, F3_ADD_SUB, 5'd10, OPC_OP_IMM));
        pad_hazard();
        put_instr(b_type(13'd8, 5'd1, 5'd1, F3_BEQ));
        put_instr(s_type(12'd40, 5'd10, 5'd0));
        put_instr(b_type(13'd8, 5'd0, 5'd10, F3_BNE));
        put_instr(s_type(12'd44, 5'd10, 5'd0));
        put_instr(b_type(13'd8, 5'd0, 5'd10, F3_BEQ));
        put_store(12, 5'd10, MARKER);
        jal_pc = 32'(prog_len * 4);
        put_instr(j_type(21'd8, 5'd11));
        put_instr(s_type(12'd52, 5'd10, 5'd0));
        pad_hazard();
        put_store(14, 5'd11, jal_pc + 32'd4);
        put_instr(i_type(12'h123, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM));
        pad_hazard();
        put_store(15, 5'd0, 32'h0);
        // Park the core in a self loop
        park_pc = 32'(prog_len * 4);
        put_instr(j_type(21'd0, 5'd0));
    endtask

    task automatic check_store();
        store_t want;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("ERROR %0t: unexpected store of %h to word %0d",
                     $time, dmem_wdata_o, dmem_addr_o);
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            assert (dmem_addr_o == want.addr && dmem_wdata_o == want.data) else begin
                errors++;
                $display("ERROR %0t: store of %h to word %0d, expected %h to word %0d",
                         $time, dmem_wdata_o, dmem_addr_o, want.data, want.addr);
            end
        end
    endtask

    // Store ports are stable half a cycle before the commit edge
    always @(negedge clk) begin
        if (!rst_i && dmem_w_en_o) begin
            check_store();
        end
        if (!rst_i && pc_o == park_pc) begin
            parked++;
        end
    end

    initial begin
        rst_i    = 1'b1;
        prog_len = 0;
        cycles   = 0;
        parked   = 0;
        errors   = 0;
        timeouts = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP_INSTR;
        end
        void'($urandom(SEED));
        a = $urandom();
        b = $urandom();
        build_program();
        limit = prog_len + 50;
        repeat (10) @(negedge clk);
        rst_i = 1'b0;
        // Last store leaves the pipeline by the second fetch of the self loop
        while (parked < 2 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (parked < 2) begin
            timeouts++;
            $display("Timeout after %0d cycles before the core reached its final loop",
                     cycles);
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected stores never reached the data memory", exp_q.size());
        end
        $display("Store errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
